// ==== src/wb_pkg.sv ====
/* Shared constants for the Wishbone subsystem: bus widths, address map and slave timing.
   Modules refer to these by scoped names. */
package wb_pkg;

    // Bus widths
    localparam int ADR_WIDTH = 14;                      // Word address
    localparam int DAT_WIDTH = 32;
    localparam int SEL_WIDTH = DAT_WIDTH / 8;           // One select per byte lane

    // Address map
    localparam int SLV_SEL_BIT = 13;                    // 0 = register bank, 1 = RAM
    localparam int OFS_WIDTH   = SLV_SEL_BIT;           // Offset inside a slave region

    // Register bank
    localparam int REG_COUNT     = 8;
    localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);

    // Word RAM, higher offset bits alias
    localparam int RAM_DEPTH     = 256;
    localparam int RAM_IDX_WIDTH = $clog2(RAM_DEPTH);
    localparam int RAM_WAIT      = 1;                   // Wait states before ack
    localparam int RAM_CNT_WIDTH = $clog2(RAM_WAIT + 1);
    localparam logic [RAM_CNT_WIDTH-1:0] RAM_WAIT_LAST = RAM_CNT_WIDTH'(RAM_WAIT);

    // Host master controller states
    localparam logic ST_IDLE   = 1'b0;
    localparam logic ST_ACTIVE = 1'b1;

endpackage

// ==== src/wb_if.sv ====
/* Classic single-access Wishbone bus, stb doubles as the cycle signal.
   Master and slave modports fix the direction of each signal. */
`timescale 1ns/100ps

interface wb_if;

    logic [wb_pkg::ADR_WIDTH-1:0] adr;          // Word address
    logic [wb_pkg::DAT_WIDTH-1:0] dat_w;        // Master to slave
    logic [wb_pkg::DAT_WIDTH-1:0] dat_r;        // Slave to master
    logic [wb_pkg::SEL_WIDTH-1:0] sel;          // Byte selects
    logic                         we;
    logic                         stb;
    logic                         ack;

    modport master (
        output adr,
        output dat_w,
        output sel,
        output we,
        output stb,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  sel,
        input  we,
        input  stb,
        output dat_r,
        output ack
    );

endinterface

// ==== src/wb_host_master.sv ====
/* Host side Wishbone master, runs one classic cycle per command strobe.
   Read data is latched on ack and completion is flagged by a done pulse. */
`timescale 1ns/100ps

module wb_host_master (
    input  logic                         m_wb_clk_i,
    input  logic                         rst_n_i,
    input  logic                         cmd_valid_i,
    input  logic                         cmd_we_i,
    input  logic [wb_pkg::ADR_WIDTH-1:0] cmd_adr_i,
    input  logic [wb_pkg::DAT_WIDTH-1:0] cmd_dat_i,
    input  logic [wb_pkg::SEL_WIDTH-1:0] cmd_sel_i,
    wb_if.master                         bus_o,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [wb_pkg::DAT_WIDTH-1:0] rdata_o
);

    logic state_q;              // Idle or active
    logic cmd_take;             // Command accepted this cycle
    logic xfer_done;            // stb and ack both high

    assign cmd_take  = (state_q == wb_pkg::ST_IDLE) && cmd_valid_i;
    assign xfer_done = (state_q == wb_pkg::ST_ACTIVE) && bus_o.stb && bus_o.ack;

    assign busy_o = (state_q == wb_pkg::ST_ACTIVE);

    // Controller, strobe and done pulse
    always_ff @(posedge m_wb_clk_i) begin
        if (!rst_n_i) begin
            state_q   <= wb_pkg::ST_IDLE;
            bus_o.stb <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                wb_pkg::ST_IDLE: begin
                    if (cmd_valid_i) begin
                        bus_o.stb <= 1'b1;              // Held until ack
                        state_q   <= wb_pkg::ST_ACTIVE;
                    end
                end
                wb_pkg::ST_ACTIVE: begin
                    if (xfer_done) begin
                        bus_o.stb <= 1'b0;
                        done_o    <= 1'b1;
                        state_q   <= wb_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state_q <= wb_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Bus payload, steady for the whole cycle
    always_ff @(posedge m_wb_clk_i) begin
        if (cmd_take) begin
            bus_o.adr   <= cmd_adr_i;
            bus_o.dat_w <= cmd_dat_i;
            bus_o.we    <= cmd_we_i;
            if (cmd_we_i) begin
                bus_o.sel <= cmd_sel_i;
            end else begin
                bus_o.sel <= '1;                        // Reads fetch the whole word
            end
        end
    end

    // Read data, held until the next read completes
    always_ff @(posedge m_wb_clk_i) begin
        if (xfer_done && !bus_o.we) begin
            rdata_o <= bus_o.dat_r;
        end
    end

endmodule

// ==== src/wb_decoder.sv ====
/* Combinational address decoder between one master and two slaves.
   The slave select bit steers stb, and the chosen slave's reply returns. */
`timescale 1ns/100ps

module wb_decoder (
    wb_if.slave  bus_m_i,
    wb_if.master bus_reg_o,
    wb_if.master bus_ram_o
);

    logic ram_sel;              // High when the access targets the RAM

    assign ram_sel = bus_m_i.adr[wb_pkg::SLV_SEL_BIT];

    // Request side, shared by both slaves
    assign bus_reg_o.adr   = bus_m_i.adr;
    assign bus_reg_o.dat_w = bus_m_i.dat_w;
    assign bus_reg_o.sel   = bus_m_i.sel;
    assign bus_reg_o.we    = bus_m_i.we;

    assign bus_ram_o.adr   = bus_m_i.adr;
    assign bus_ram_o.dat_w = bus_m_i.dat_w;
    assign bus_ram_o.sel   = bus_m_i.sel;
    assign bus_ram_o.we    = bus_m_i.we;

    // Only the selected slave sees the strobe
    assign bus_reg_o.stb = bus_m_i.stb && !ram_sel;
    assign bus_ram_o.stb = bus_m_i.stb && ram_sel;

    // Reply side
    always_comb begin
        if (ram_sel) begin
            bus_m_i.ack   = bus_ram_o.ack;
            bus_m_i.dat_r = bus_ram_o.dat_r;
        end else begin
            bus_m_i.ack   = bus_reg_o.ack;
            bus_m_i.dat_r = bus_reg_o.dat_r;
        end
    end

endmodule

// ==== src/wb_reg_bank.sv ====
/* Bank of byte-writable registers on the Wishbone slave side.
   Acks one cycle after stb, offsets beyond the bank read zero. */
`timescale 1ns/100ps

module wb_reg_bank (
    input  logic m_wb_clk_i,
    input  logic rst_n_i,
    wb_if.slave  bus_i
);

    logic [wb_pkg::DAT_WIDTH-1:0]     regs [wb_pkg::REG_COUNT];
    logic [wb_pkg::REG_IDX_WIDTH-1:0] idx;
    logic                             in_range;
    logic                             acc_en;       // Cycle on which ack is raised

    assign idx      = bus_i.adr[wb_pkg::REG_IDX_WIDTH-1:0];
    assign in_range = (bus_i.adr[wb_pkg::OFS_WIDTH-1:wb_pkg::REG_IDX_WIDTH] == '0);
    assign acc_en   = bus_i.stb && !bus_i.ack;

    // Single cycle ack, never back to back
    always_ff @(posedge m_wb_clk_i) begin
        if (!rst_n_i) begin
            bus_i.ack <= 1'b0;
        end else begin
            bus_i.ack <= acc_en;
        end
    end

    // Byte lane writes
    always_ff @(posedge m_wb_clk_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < wb_pkg::REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (acc_en && bus_i.we && in_range) begin
            for (int b = 0; b < wb_pkg::SEL_WIDTH; b++) begin
                if (bus_i.sel[b]) begin
                    regs[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
                end
            end
        end
    end

    // Read data registered alongside ack
    always_ff @(posedge m_wb_clk_i) begin
        if (acc_en) begin
            if (in_range) begin
                bus_i.dat_r <= regs[idx];
            end else begin
                bus_i.dat_r <= '0;              // Hole in the register map
            end
        end
    end

endmodule

// ==== src/wb_ram.sv ====
/* Word RAM slave with byte enables, contents are not reset.
   A wait counter holds off ack for the configured number of wait states. */
`timescale 1ns/100ps

module wb_ram (
    input  logic m_wb_clk_i,
    input  logic rst_n_i,
    wb_if.slave  bus_i
);

    logic [wb_pkg::DAT_WIDTH-1:0]     mem [wb_pkg::RAM_DEPTH];
    logic [wb_pkg::RAM_IDX_WIDTH-1:0] idx;
    logic [wb_pkg::RAM_CNT_WIDTH-1:0] wait_q;
    logic                             pending;      // stb seen, ack not yet given
    logic                             acc_en;       // Last wait state passed

    assign idx     = bus_i.adr[wb_pkg::RAM_IDX_WIDTH-1:0];   // Upper offset bits alias
    assign pending = bus_i.stb && !bus_i.ack;
    assign acc_en  = pending && (wait_q == wb_pkg::RAM_WAIT_LAST);

    // Wait counter and ack
    always_ff @(posedge m_wb_clk_i) begin
        if (!rst_n_i) begin
            wait_q    <= '0;
            bus_i.ack <= 1'b0;
        end else begin
            bus_i.ack <= acc_en;
            if (pending && !acc_en) begin
                wait_q <= wait_q + 1'b1;
            end else begin
                wait_q <= '0;
            end
        end
    end

    // Storage and registered read
    always_ff @(posedge m_wb_clk_i) begin
        if (acc_en) begin
            if (bus_i.we) begin
                for (int b = 0; b < wb_pkg::SEL_WIDTH; b++) begin
                    if (bus_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
                    end
                end
            end
            bus_i.dat_r <= mem[idx];
        end
    end

endmodule

// ==== src/wb_subsys_top.sv ====
/* Top level of the Wishbone subsystem with a plain command port.
   Connects the host master through the decoder to the register bank and RAM. */
`timescale 1ns/100ps

module wb_subsys_top (
    input  logic                         m_wb_clk_i,
    input  logic                         rst_n_i,
    input  logic                         cmd_valid_i,
    input  logic                         cmd_we_i,
    input  logic [wb_pkg::ADR_WIDTH-1:0] cmd_adr_i,
    input  logic [wb_pkg::DAT_WIDTH-1:0] cmd_dat_i,
    input  logic [wb_pkg::SEL_WIDTH-1:0] cmd_sel_i,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [wb_pkg::DAT_WIDTH-1:0] rdata_o
);

    wb_if bus_m ();             // Master to decoder
    wb_if bus_s [2] ();         // 0 is the register bank, 1 the RAM

    wb_host_master u_master (
        .m_wb_clk_i  (m_wb_clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_we_i    (cmd_we_i),
        .cmd_adr_i   (cmd_adr_i),
        .cmd_dat_i   (cmd_dat_i),
        .cmd_sel_i   (cmd_sel_i),
        .bus_o       (bus_m),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o)
    );

    wb_decoder u_decoder (
        .bus_m_i   (bus_m),
        .bus_reg_o (bus_s[0]),
        .bus_ram_o (bus_s[1])
    );

    wb_reg_bank u_reg_bank (
        .m_wb_clk_i (m_wb_clk_i),
        .rst_n_i    (rst_n_i),
        .bus_i      (bus_s[0])
    );

    wb_ram u_ram (
        .m_wb_clk_i (m_wb_clk_i),
        .rst_n_i    (rst_n_i),
        .bus_i      (bus_s[1])
    );

endmodule

// ==== verif/wb_subsys_properties.sv ====
/* Wishbone protocol checks on the host master side of the bus.
   Attached to every wb_host_master instance by the bind below. */
`timescale 1ns/100ps

module wb_subsys_properties (
    input logic                         m_wb_clk_i,
    input logic                         rst_n_i,
    input logic                         stb_i,
    input logic                         ack_i,
    input logic [wb_pkg::ADR_WIDTH-1:0] adr_i,
    input logic                         busy_i,
    input logic                         done_i
);

    // Strobe and address stay put until the slave answers
    a_stb_hold: assert property (
        @(posedge m_wb_clk_i) disable iff (!rst_n_i)
        (stb_i && !ack_i) |=> (stb_i && $stable(adr_i))
    ) else $error("stb dropped or adr moved before ack");

    a_ack_with_stb: assert property (
        @(posedge m_wb_clk_i) disable iff (!rst_n_i)
        ack_i |-> stb_i
    ) else $error("ack high without stb");

    a_done_pulse: assert property (
        @(posedge m_wb_clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i
    ) else $error("done_o longer than one cycle");

    // Sync reset leaves the master idle
    a_reset_idle: assert property (
        @(posedge m_wb_clk_i)
        !rst_n_i |=> (!busy_i && !done_i)
    ) else $error("busy_o or done_o high after reset");

endmodule

bind wb_host_master wb_subsys_properties u_props (
    .m_wb_clk_i (m_wb_clk_i),
    .rst_n_i    (rst_n_i),
    .stb_i      (bus_o.stb),
    .ack_i      (bus_o.ack),
    .adr_i      (bus_o.adr),
    .busy_i     (busy_o),
    .done_i     (done_o)
);

// ==== verif/tb_wb_subsys.sv ====
/* Testbench for the Wishbone subsystem. Issues single accesses through the command port
   and checks read data, held rdata_o and command-to-done latency against shadow models. */
`timescale 1ns/100ps

module tb_wb_subsys;

    localparam int SEED          = 42896;
    localparam int N_REG_PAIRS   = 40;                  // Write then read, in range
    localparam int N_REG_HOLES   = 8;                   // Write then read, above the bank
    localparam int N_RAM_PAIRS   = 40;                  // Write then read through an alias
    localparam int N_DROP        = 3;
    localparam int N_MIXED       = 200;
    localparam int N_ACCESSES    = 2 * N_REG_PAIRS + 2 * N_REG_HOLES + wb_pkg::RAM_DEPTH
                                 + 2 * N_RAM_PAIRS + N_DROP + N_MIXED;
    localparam int CYC_PER_ACC   = 5;                   // Issue cycle plus RAM latency
    localparam int TIMEOUT_CYC   = CYC_PER_ACC * N_ACCESSES + 100;
    localparam int OFS_SPAN      = 2 ** wb_pkg::OFS_WIDTH;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         cmd_valid;
    logic                         cmd_we;
    logic [wb_pkg::ADR_WIDTH-1:0] cmd_adr;
    logic [wb_pkg::DAT_WIDTH-1:0] cmd_dat;
    logic [wb_pkg::SEL_WIDTH-1:0] cmd_sel;
    logic                         busy;
    logic                         done;
    logic [wb_pkg::DAT_WIDTH-1:0] rdata;

    logic [wb_pkg::DAT_WIDTH-1:0] shadow_reg [wb_pkg::REG_COUNT];
    logic [wb_pkg::DAT_WIDTH-1:0] shadow_ram [wb_pkg::RAM_DEPTH];

    // One entry per accepted command, popped at its done pulse
    logic                         exp_we_q  [$];
    logic [wb_pkg::ADR_WIDTH-1:0] exp_adr_q [$];
    logic [wb_pkg::DAT_WIDTH-1:0] exp_dat_q [$];
    int                           exp_lat_q [$];
    int                           start_q   [$];

    logic [wb_pkg::DAT_WIDTH-1:0] last_rdata = '0;
    logic                         have_read  = 1'b0;
    int                           cycle_cnt  = 0;
    int                           issued     = 0;
    int                           completed  = 0;

    wb_subsys_top dut0 (
        .m_wb_clk_i  (clk),
        .rst_n_i     (rst_n),
        .cmd_valid_i (cmd_valid),
        .cmd_we_i    (cmd_we),
        .cmd_adr_i   (cmd_adr),
        .cmd_dat_i   (cmd_dat),
        .cmd_sel_i   (cmd_sel),
        .busy_o      (busy),
        .done_o      (done),
        .rdata_o     (rdata)
    );

    always #4 clk = ~clk;

    function automatic logic [wb_pkg::ADR_WIDTH-1:0] reg_adr(input int ofs);
        return {1'b0, wb_pkg::OFS_WIDTH'(ofs)};
    endfunction

    function automatic logic [wb_pkg::ADR_WIDTH-1:0] ram_adr(input int ofs);
        return {1'b1, wb_pkg::OFS_WIDTH'(ofs)};
    endfunction

    // Every byte depends on the full word index
    function automatic logic [wb_pkg::DAT_WIDTH-1:0] fill_word(input int i);
        return {8'(i), ~8'(i), 8'(i) ^ 8'h3c, 8'(i * 7)};
    endfunction

    function automatic logic [wb_pkg::DAT_WIDTH-1:0] merge_bytes(
        input logic [wb_pkg::DAT_WIDTH-1:0] old,
        input logic [wb_pkg::DAT_WIDTH-1:0] dat,
        input logic [wb_pkg::SEL_WIDTH-1:0] sel
    );
        logic [wb_pkg::DAT_WIDTH-1:0] res;
        res = old;
        for (int b = 0; b < wb_pkg::SEL_WIDTH; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = dat[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Reference model of the address map
    function automatic logic [wb_pkg::DAT_WIDTH-1:0] ref_read(
        input logic [wb_pkg::ADR_WIDTH-1:0] adr
    );
        int ofs;
        ofs = int'(adr[wb_pkg::OFS_WIDTH-1:0]);
        if (adr[wb_pkg::SLV_SEL_BIT]) begin
            return shadow_ram[wb_pkg::RAM_IDX_WIDTH'(ofs % wb_pkg::RAM_DEPTH)];
        end else if (ofs >= wb_pkg::REG_COUNT) begin
            return '0;                                  // Register map hole
        end
        return shadow_reg[wb_pkg::REG_IDX_WIDTH'(ofs)];
    endfunction

    function automatic void ref_write(
        input logic [wb_pkg::ADR_WIDTH-1:0] adr,
        input logic [wb_pkg::DAT_WIDTH-1:0] dat,
        input logic [wb_pkg::SEL_WIDTH-1:0] sel
    );
        int ofs;
        logic [wb_pkg::RAM_IDX_WIDTH-1:0] ridx;
        ofs  = int'(adr[wb_pkg::OFS_WIDTH-1:0]);
        ridx = wb_pkg::RAM_IDX_WIDTH'(ofs % wb_pkg::RAM_DEPTH);
        if (adr[wb_pkg::SLV_SEL_BIT]) begin
            shadow_ram[ridx] = merge_bytes(shadow_ram[ridx], dat, sel);
        end else if (ofs < wb_pkg::REG_COUNT) begin
            shadow_reg[wb_pkg::REG_IDX_WIDTH'(ofs)] =
                merge_bytes(shadow_reg[wb_pkg::REG_IDX_WIDTH'(ofs)], dat, sel);
        end
    endfunction

    function automatic int ref_latency(input logic [wb_pkg::ADR_WIDTH-1:0] adr);
        return adr[wb_pkg::SLV_SEL_BIT] ? 3 + wb_pkg::RAM_WAIT : 3;
    endfunction

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_data(
        input logic [wb_pkg::DAT_WIDTH-1:0] got,
        input logic [wb_pkg::DAT_WIDTH-1:0] exp,
        input string                        what
    );
        if (got !== exp) begin
            fail_run($sformatf("ERR @%0t: %s got %08h expected %08h", $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("ERR @%0t: %s took %0d cycles expected %0d",
                               $time, what, got, exp));
        end
    endtask

    // Drive one command for a single cycle, record what its completion must show
    task automatic issue_cmd(
        input logic                         we,
        input logic [wb_pkg::ADR_WIDTH-1:0] adr,
        input logic [wb_pkg::DAT_WIDTH-1:0] dat,
        input logic [wb_pkg::SEL_WIDTH-1:0] sel
    );
        if (busy) begin
            fail_run("busy_o was high while the master should be idle");
        end
        cmd_valid <= 1'b1;
        cmd_we    <= we;
        cmd_adr   <= adr;
        cmd_dat   <= dat;
        cmd_sel   <= sel;
        @(posedge clk);                                 // DUT takes the command here
        cmd_valid <= 1'b0;
        exp_we_q.push_back(we);
        exp_adr_q.push_back(adr);
        exp_dat_q.push_back(ref_read(adr));
        exp_lat_q.push_back(ref_latency(adr));
        start_q.push_back(cycle_cnt);
        issued++;
        if (we) begin
            ref_write(adr, dat, sel);
        end
    endtask

    task automatic wait_done();
        do begin
            @(posedge clk);
        end while (!done);
    endtask

    task automatic run_access(
        input logic                         we,
        input logic [wb_pkg::ADR_WIDTH-1:0] adr,
        input logic [wb_pkg::DAT_WIDTH-1:0] dat,
        input logic [wb_pkg::SEL_WIDTH-1:0] sel
    );
        issue_cmd(we, adr, dat, sel);
        wait_done();
    endtask

    // Register write strobed during a RAM read must vanish
    task automatic drop_while_busy();
        logic [wb_pkg::ADR_WIDTH-1:0] victim;
        victim = reg_adr(5);
        run_access(1'b1, victim, 32'h1234_5678, '1);
        issue_cmd(1'b0, ram_adr(3), '0, '0);
        @(posedge clk);
        if (!busy) begin
            fail_run("busy_o was low in the middle of a RAM access");
        end
        cmd_valid <= 1'b1;
        cmd_we    <= 1'b1;
        cmd_adr   <= victim;
        cmd_dat   <= 32'hdead_beef;
        cmd_sel   <= '1;
        @(posedge clk);
        cmd_valid <= 1'b0;
        wait_done();
        run_access(1'b0, victim, '0, '0);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC));
        end
    end

    // Compare each completion with the reference model
    always @(posedge clk) begin : compare
        logic                         c_we;
        logic [wb_pkg::ADR_WIDTH-1:0] c_adr;
        logic [wb_pkg::DAT_WIDTH-1:0] c_dat;
        int                           c_lat;
        int                           c_start;
        if (done) begin
            if (exp_we_q.size() == 0) begin
                fail_run("done_o pulsed with no accepted command outstanding");
            end
            c_we    = exp_we_q.pop_front();
            c_adr   = exp_adr_q.pop_front();
            c_dat   = exp_dat_q.pop_front();
            c_lat   = exp_lat_q.pop_front();
            c_start = start_q.pop_front();
            check_latency(cycle_cnt - c_start, c_lat, $sformatf("access to %04h", c_adr));
            if (!c_we) begin
                check_data(rdata, c_dat, $sformatf("read of %04h", c_adr));
                last_rdata = c_dat;
                have_read  = 1'b1;
            end else if (have_read) begin
                check_data(rdata, last_rdata, "rdata_o after a write");
            end
            completed++;
        end else if (have_read) begin
            check_data(rdata, last_rdata, "rdata_o between reads");   // Must hold
        end
    end

    initial begin : stimulus
        logic [wb_pkg::ADR_WIDTH-1:0] adr;
        int                           ofs;
        void'($urandom(SEED));
        rst_n     <= 1'b0;
        cmd_valid <= 1'b0;
        cmd_we    <= 1'b0;
        cmd_adr   <= '0;
        cmd_dat   <= '0;
        cmd_sel   <= '0;
        for (int r = 0; r < wb_pkg::REG_COUNT; r++) begin
            shadow_reg[r] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < N_REG_PAIRS; i++) begin
            ofs = int'($urandom_range(wb_pkg::REG_COUNT - 1, 0));
            run_access(1'b1, reg_adr(ofs), wb_pkg::DAT_WIDTH'($urandom),
                       wb_pkg::SEL_WIDTH'($urandom));
            run_access(1'b0, reg_adr(ofs), '0, '0);
        end
        for (int i = 0; i < N_REG_HOLES; i++) begin
            ofs = int'($urandom_range(OFS_SPAN - 1, wb_pkg::REG_COUNT));
            run_access(1'b1, reg_adr(ofs), wb_pkg::DAT_WIDTH'($urandom), '1);
            run_access(1'b0, reg_adr(ofs), '0, '0);
        end

        for (int i = 0; i < wb_pkg::RAM_DEPTH; i++) begin
            run_access(1'b1, ram_adr(i), fill_word(i), '1);        // RAM has no reset
        end
        for (int i = 0; i < N_RAM_PAIRS; i++) begin
            ofs = int'($urandom_range(OFS_SPAN - 1, 0));
            run_access(1'b1, ram_adr(ofs), wb_pkg::DAT_WIDTH'($urandom),
                       wb_pkg::SEL_WIDTH'($urandom));
            ofs = (ofs + wb_pkg::RAM_DEPTH * int'($urandom_range(31, 1))) % OFS_SPAN;
            run_access(1'b0, ram_adr(ofs), '0, '0);                // Same word, other alias
        end

        drop_while_busy();

        for (int i = 0; i < N_MIXED; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                adr = ram_adr(int'($urandom_range(OFS_SPAN - 1, 0)));
            end else begin
                adr = reg_adr(int'($urandom_range(2 * wb_pkg::REG_COUNT - 1, 0)));
            end
            run_access(1'($urandom), adr, wb_pkg::DAT_WIDTH'($urandom),
                       wb_pkg::SEL_WIDTH'($urandom));
        end

        repeat (10) @(posedge clk);                                 // Catch stray done pulses
        if (completed != issued) begin
            fail_run($sformatf("Completion count is off: %0d issued, %0d completed",
                               issued, completed));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
src/wb_pkg.sv
src/wb_if.sv
src/wb_host_master.sv
src/wb_decoder.sv
src/wb_reg_bank.sv
src/wb_ram.sv
src/wb_subsys_top.sv
verif/wb_subsys_properties.sv
verif/tb_wb_subsys.sv

// ==== Makefile ====
# Verilator build and run for the Wishbone subsystem testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --timescale $(TIMESCALE) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: $(SIM_BIN)
	$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
